/* compile.f */
verilog/audio_pkg.sv
verilog/adc_ingress.sv
verilog/channel_mixer.sv
verilog/dac_egress_fsm.sv
verilog/event_timer.sv
verilog/clip_monitor.sv
verilog/audio_core.sv
test/audio_core_checker.sv
test/audio_core_scoreboard.sv
test/audio_core_tb.sv

/* test/audio_core_checker.sv */
/* bound assertions: DAC beat stability under stall,
   left/right ordering, one-cycle timer ticks */

`timescale 1ns/1ps
`default_nettype none

module audio_core_checker import audio_pkg::*; (
  input wire          clk,
  input wire          rst_n,
  input wire sample_t dac_data,
  input wire          dac_valid,
  input wire          dac_last,
  input wire          dac_ready,
  input wire          tick
);

  int fail_count;  // failed assertions so far

  initial begin
    fail_count = 0;
  end

  // ------------------------------
  // dac stream
  // ------------------------------
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      dac_valid && !dac_ready |=> $stable(dac_data) && $stable(dac_last))
    else begin
      fail_count++;
      $error("DAC beat changed while dac_ready was low");
    end

  // left beat moved, right beat must be up next
  a_right_follows: assert property (@(posedge clk) disable iff (!rst_n)
      dac_valid && dac_ready && !dac_last |=> dac_valid && dac_last)
    else begin
      fail_count++;
      $error("left DAC beat not followed by a right beat");
    end

  // ------------------------------
  // timers
  // ------------------------------
  a_tick_width: assert property (@(posedge clk) disable iff (!rst_n)
      tick |=> !tick)
    else begin
      fail_count++;
      $error("timer tick wider than one cycle");
    end

endmodule

`default_nettype wire

/* test/audio_core_scoreboard.sv */
/* scoreboard: mixer reference model, DAC order and latency,
   peak, clip hold, interrupt and blink checks */

`timescale 1ns/1ps
`default_nettype none

module audio_core_scoreboard import audio_pkg::*; #(
  parameter int IRQ0_PERIOD       = 40,
  parameter int IRQ1_PERIOD       = 25,
  parameter int BLINK_HALF_PERIOD = 30,
  parameter int CLIP_HOLD_CYCLES  = 50
) (
  input  wire            clk,
  input  wire            rst_n,
  input  wire sample_t   adc_data,
  input  wire            adc_valid,
  input  wire            adc_last,
  input  wire sample_t   aux_data,
  input  wire mix_ctrl_t mix_ctrl,
  input  wire            clear_peaks,
  input  wire sample_t   dac_data,
  input  wire            dac_valid,
  input  wire            dac_last,
  input  wire            dac_ready,
  input  wire sample_t   peak_max,
  input  wire sample_t   peak_min,
  input  wire            led_1,
  input  wire            led_2,
  input  wire            led_3,
  input  wire            irq_0,
  input  wire            irq_1,
  output int             error_count
);

  localparam int     LATENCY = 4;         // right adc beat to first dac beat
  localparam longint S_MAX   = 8388607;   // 24-bit signed limits
  localparam longint S_MIN   = -8388608;

  int      cyc;          // edges since reset release
  sample_t left_seen;
  sample_t pmax_m;
  sample_t pmin_m;
  logic    led2_m;
  int      lit_left;     // remaining led_1 cycles
  logic    beat;         // 0 left, 1 right
  logic    prev_valid;
  sample_t exp_left[$];
  sample_t exp_right[$];
  int      exp_time[$];
  int      clip_due[$];  // edge where the monitor sees a clip

  initial begin
    error_count = 0;
  end

  task automatic compare_value(input string sig, input longint exp, input longint got);
    if (exp != got) begin
      error_count++;
      $display("** Error at %0d ns: %s expected %0d, got %0d", $time, sig, exp, got);
    end
  endtask

  task automatic report_problem(input string what);
    error_count++;
    $display("at %0d ns: %s", $time, what);
  endtask

  // ------------------------------
  // mixer model
  // ------------------------------
  function automatic longint limit_to_sample(input longint v, inout logic hit);
    longint r;
    r = v;
    if (v > S_MAX) begin
      r   = S_MAX;
      hit = 1'b1;
    end else if (v < S_MIN) begin
      r   = S_MIN;
      hit = 1'b1;
    end
    return r;
  endfunction

  // Q13.11 gain, floor shift
  function automatic longint apply_gain(input longint x, input longint g, inout logic hit);
    return limit_to_sample((x * g) >>> Q_BITS, hit);
  endfunction

  task automatic predict_pair();
    sample_t smp [NR_OF_CHANNELS];
    longint  side [2];   // [0] left, [1] right
    logic    ch_hit;
    logic    out_hit;
    smp[0]  = left_seen;
    smp[1]  = adc_data;
    smp[2]  = aux_data;
    side[0] = 0;
    side[1] = 0;
    ch_hit  = 1'b0;
    out_hit = 1'b0;
    for (int i = 0; i < NR_OF_CHANNELS; i++) begin
      side[mix_ctrl.pan[i]] += apply_gain(longint'(smp[i]),
                                          longint'(mix_ctrl.ch_gain[i]), ch_hit);
    end
    for (int s = 0; s < 2; s++) begin
      side[s] = limit_to_sample(side[s], out_hit);
      side[s] = apply_gain(side[s], longint'(mix_ctrl.out_gain), out_hit);
    end
    exp_left.push_back(sample_t'(side[0]));
    exp_right.push_back(sample_t'(side[1]));
    exp_time.push_back(cyc);
    if (ch_hit || out_hit) begin
      clip_due.push_back(cyc + 3);  // two mixer stages, then the monitor edge
    end
  endtask

  // ------------------------------
  // per edge checks
  // ------------------------------
  task automatic score_dac_beat();
    sample_t exp_data;
    if (dac_valid) begin
      if (exp_left.size() == 0) begin
        if (!prev_valid) begin
          report_problem("dac_valid went high with no mixed pair pending");
        end
      end else begin
        if (!prev_valid) begin
          compare_value("dac_valid latency", LATENCY, cyc - exp_time[0]);
        end
        exp_data = beat ? exp_right[0] : exp_left[0];
        compare_value("dac_data", exp_data, dac_data);
        compare_value("dac_last", beat, dac_last);
        if (dac_ready) begin
          if (beat) begin
            exp_left.delete(0);
            exp_right.delete(0);
            exp_time.delete(0);
          end
          beat = !beat;
        end
      end
    end
    prev_valid = dac_valid;
  endtask

  task automatic track_peaks();
    compare_value("peak_max", pmax_m, peak_max);
    compare_value("peak_min", pmin_m, peak_min);
    compare_value("led_2", led2_m, led_2);
    if (clear_peaks) begin   // clear beats a sample
      pmax_m = '0;
      pmin_m = '0;
      led2_m = !led2_m;
    end else if (adc_valid) begin
      if (adc_data > pmax_m) begin
        pmax_m = adc_data;
      end
      if (adc_data < pmin_m) begin
        pmin_m = adc_data;
      end
    end
  endtask

  task automatic model_clip_hold();
    logic clip_in;
    clip_in = 1'b0;
    compare_value("led_1", lit_left > 0, led_1);
    if (clip_due.size() > 0 && clip_due[0] == cyc) begin
      clip_in = 1'b1;
      clip_due.delete(0);
    end
    if (lit_left > 0) begin
      lit_left--;            // clips during the hold are ignored
    end else if (clip_in) begin
      lit_left = CLIP_HOLD_CYCLES + 1;
    end
  endtask

  task automatic timers_expected();
    int k;
    k = cyc - 1;
    compare_value("irq_0", (k > 0) && (k % IRQ0_PERIOD == 0), irq_0);
    compare_value("irq_1", (k > 0) && (k % IRQ1_PERIOD == 0), irq_1);
    compare_value("led_3", (k / BLINK_HALF_PERIOD) % 2, led_3);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      compare_value("dac_valid", 0, dac_valid);
      compare_value("dac_last", 0, dac_last);
      compare_value("irq_0", 0, irq_0);
      compare_value("irq_1", 0, irq_1);
      compare_value("led_1", 0, led_1);
      compare_value("led_2", 0, led_2);
      compare_value("led_3", 0, led_3);
      compare_value("peak_max", 0, peak_max);
      compare_value("peak_min", 0, peak_min);
      cyc        = 0;
      pmax_m     = '0;
      pmin_m     = '0;
      led2_m     = 1'b0;
      lit_left   = 0;
      beat       = 1'b0;
      prev_valid = 1'b0;
      exp_left.delete();
      exp_right.delete();
      exp_time.delete();
      clip_due.delete();
    end else begin
      cyc++;
      timers_expected();
      track_peaks();
      model_clip_hold();
      score_dac_beat();
      if (adc_valid && !adc_last) begin
        left_seen = adc_data;
      end
      if (adc_valid && adc_last) begin
        predict_pair();
      end
    end
  end

endmodule

`default_nettype wire

/* test/audio_core_tb.sv */
/* audio core testbench with clock, reset, LFSR stimulus, DUT and
   scoreboard, bound checkers, watchdog and final report */

`timescale 1ns/1ps
`default_nettype none

module audio_core_tb
  import audio_pkg::*;
();

  localparam int IRQ0_PERIOD       = 40;
  localparam int IRQ1_PERIOD       = 25;
  localparam int BLINK_HALF_PERIOD = 30;
  localparam int CLIP_HOLD_CYCLES  = 50;

  localparam int PAIRS_PER_TEST  = 24;
  localparam int PAIR_TIMEOUT    = 64;                 // cycles for one DAC pair
  localparam int PAIR_CYCLES_MAX = PAIR_TIMEOUT + 12;  // plus beat gaps and spacing
  localparam int TIMER_CYCLES    = 150;
  localparam int WATCHDOG_CYCLES = 20 + 4 * PAIRS_PER_TEST * PAIR_CYCLES_MAX
                                   + CLIP_HOLD_CYCLES + TIMER_CYCLES + 200;

  logic        clk;
  logic        rst_n;
  sample_t     adc_data;
  logic        adc_valid;
  logic        adc_last;
  sample_t     aux_data;
  mix_ctrl_t   mix_ctrl;
  logic        clear_peaks;
  sample_t     dac_data;
  logic        dac_valid;
  logic        dac_last;
  logic        dac_ready;
  sample_t     peak_max;
  sample_t     peak_min;
  logic        led_1;
  logic        led_2;
  logic        led_3;
  logic        irq_0;
  logic        irq_1;
  logic [31:0] stim_state;
  logic [31:0] ready_state;
  logic        stall_enable;  // random dac_ready when set
  int          sb_errors;
  int          tb_errors;
  int          tests_run;
  int          tests_failed;
  int          errors_at_start;

  audio_core #(
    .IRQ0_PERIOD       ( IRQ0_PERIOD       ),
    .IRQ1_PERIOD       ( IRQ1_PERIOD       ),
    .BLINK_HALF_PERIOD ( BLINK_HALF_PERIOD ),
    .CLIP_HOLD_CYCLES  ( CLIP_HOLD_CYCLES  )
  ) audio_core_i (.*);

  audio_core_scoreboard #(
    .IRQ0_PERIOD       ( IRQ0_PERIOD       ),
    .IRQ1_PERIOD       ( IRQ1_PERIOD       ),
    .BLINK_HALF_PERIOD ( BLINK_HALF_PERIOD ),
    .CLIP_HOLD_CYCLES  ( CLIP_HOLD_CYCLES  )
  ) scoreboard_i (.*, .error_count(sb_errors));

  bind dac_egress_fsm audio_core_checker dac_stream_chk (
    .clk(clk), .rst_n(rst_n), .dac_data(dac_data), .dac_valid(dac_valid),
    .dac_last(dac_last), .dac_ready(dac_ready), .tick(1'b0)
  );

  bind event_timer audio_core_checker tick_chk (
    .clk(clk), .rst_n(rst_n), .dac_data('0), .dac_valid(1'b0),
    .dac_last(1'b0), .dac_ready(1'b0), .tick(tick)
  );

  // ------------------------------
  // clock, lfsr, helpers
  // ------------------------------
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
      state = {state[30:0], fb};
      val   = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic int total_errors();
    return sb_errors + tb_errors
         + audio_core_i.dac_egress_fsm_i.dac_stream_chk.fail_count
         + audio_core_i.irq0_timer.tick_chk.fail_count
         + audio_core_i.irq1_timer.tick_chk.fail_count
         + audio_core_i.blink_timer.tick_chk.fail_count;
  endfunction

  always @(posedge clk) begin
    if (stall_enable) begin
      dac_ready <= (take_bits(ready_state, 2) != 0);  // low about one cycle in four
    end else begin
      dac_ready <= 1'b1;
    end
  end

  task automatic set_mix(input logic unity);
    mix_ctrl_t m;
    for (int i = 0; i < NR_OF_CHANNELS; i++) begin
      m.ch_gain[i] = unity ? gain_t'(2048) : gain_t'(take_bits(stim_state, 14));
    end
    m.pan      = 3'(take_bits(stim_state, 3));
    m.out_gain = unity ? gain_t'(2048) : gain_t'(take_bits(stim_state, 13));
    @(posedge clk);
    mix_ctrl <= m;
  endtask

  // bounded wait for the right dac beat handshake
  task automatic wait_pair_done();
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < PAIR_TIMEOUT) begin
      @(posedge clk);
      waited++;
      done = dac_valid && dac_ready && dac_last;
    end
    if (!done) begin
      tb_errors++;
      $display("at %0d ns: no DAC pair completed within %0d cycles", $time, PAIR_TIMEOUT);
    end
  endtask

  task automatic send_pair(input logic with_clear);
    int gap;
    gap = int'(take_bits(stim_state, 2));
    @(posedge clk);
    adc_data    <= sample_t'(take_bits(stim_state, 24));
    adc_valid   <= 1'b1;
    adc_last    <= 1'b0;
    clear_peaks <= with_clear;   // may land on the left beat
    for (int i = 0; i < gap; i++) begin
      @(posedge clk);
      adc_valid   <= 1'b0;
      clear_peaks <= 1'b0;
    end
    @(posedge clk);
    adc_data    <= sample_t'(take_bits(stim_state, 24));
    aux_data    <= sample_t'(take_bits(stim_state, 24));
    adc_valid   <= 1'b1;
    adc_last    <= 1'b1;
    clear_peaks <= 1'b0;
    @(posedge clk);
    adc_valid <= 1'b0;
    adc_last  <= 1'b0;
    wait_pair_done();
    repeat (2) @(posedge clk);   // egress idle before the next pair
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = total_errors() - errors_at_start;
    tests_run++;
    if (errs == 0) begin
      $display("[%0d ns] test %s: ok", $time, name);
    end else begin
      tests_failed++;
      $display("[%0d ns] test %s: FAILED with %0d errors", $time, name, errs);
    end
    errors_at_start = total_errors();
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    rst_n           = 1'b0;
    adc_data        = '0;
    adc_valid       = 1'b0;
    adc_last        = 1'b0;
    aux_data        = '0;
    mix_ctrl        = '0;
    clear_peaks     = 1'b0;
    dac_ready       = 1'b0;
    stall_enable    = 1'b0;
    tb_errors       = 0;
    tests_run       = 0;
    tests_failed    = 0;
    errors_at_start = 0;
    stim_state      = 32'he7c6_daf8;
    ready_state     = take_bits(stim_state, 32);

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    end_test("reset values");

    for (int i = 0; i < PAIRS_PER_TEST; i++) begin
      if (i % 6 == 0) begin
        set_mix(1'b1);  // new random pan
      end
      send_pair(1'b0);
    end
    end_test("unity gain mixing");

    for (int i = 0; i < PAIRS_PER_TEST; i++) begin
      if (i % 6 == 0) begin
        set_mix(1'b0);
      end
      send_pair(1'b0);
    end
    repeat (CLIP_HOLD_CYCLES + 10) @(posedge clk);  // let the last hold run out
    end_test("random gains and clip hold");

    stall_enable <= 1'b1;
    for (int i = 0; i < PAIRS_PER_TEST; i++) begin
      if (i % 6 == 0) begin
        set_mix(1'b0);
      end
      send_pair(1'b0);
    end
    stall_enable <= 1'b0;
    end_test("dac back-pressure");

    for (int i = 0; i < PAIRS_PER_TEST; i++) begin
      send_pair(take_bits(stim_state, 2) == 0);
    end
    @(posedge clk);
    clear_peaks <= 1'b1;   // clear with no beat
    @(posedge clk);
    clear_peaks <= 1'b0;
    repeat (3) @(posedge clk);
    end_test("peak capture and clear");

    repeat (TIMER_CYCLES) @(posedge clk);
    end_test("interrupt and blink timers");

    $display("%0d tests run, %0d failed, %0d errors in total",
             tests_run, tests_failed, total_errors());
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // ------------------------------
  // watchdog
  // ------------------------------
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/adc_ingress.sv */
/* ADC ingress: left/right pairing into a mixer frame with aux,
   signed peak capture and the peak clear indicator */

`timescale 1ns/1ps
`default_nettype none

module adc_ingress import audio_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire sample_t adc_data,
  input  wire          adc_valid,
  input  wire          adc_last,     // high on the right sample
  input  wire sample_t aux_data,
  input  wire          clear_peaks,  // one-cycle command
  output mix_frame_t   frame,
  output logic         frame_valid,
  output sample_t      peak_max,
  output sample_t      peak_min,
  output logic         led_2
);

  logic take_left;
  logic take_right;

  assign take_left  = adc_valid && !adc_last;
  assign take_right = adc_valid && adc_last;

  // ------------------------------
  // frame assembly
  // ------------------------------
  always_ff @(posedge clk) begin
    if (take_left) begin
      frame.ch[0] <= adc_data;
    end
    if (take_right) begin
      frame.ch[1] <= adc_data;
      frame.ch[2] <= aux_data;  // aux sampled with the right beat
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= take_right;  // single cycle strobe
    end
  end

  // ------------------------------
  // peak tracking
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      peak_max <= '0;
      peak_min <= '0;
      led_2    <= 1'b0;
    end else if (clear_peaks) begin  // clear wins over a sample
      peak_max <= '0;
      peak_min <= '0;
      led_2    <= ~led_2;
    end else if (adc_valid) begin
      if (adc_data > peak_max) begin
        peak_max <= adc_data;
      end
      if (adc_data < peak_min) begin
        peak_min <= adc_data;  // kept signed
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/audio_core.sv */
/* audio core top level: ADC ingress, channel mixer, DAC egress,
   clip monitor, interrupt and blink timers */

`timescale 1ns/1ps
`default_nettype none

module audio_core import audio_pkg::*; #(
  parameter int IRQ0_PERIOD       = 12_500_000,
  parameter int IRQ1_PERIOD       = 12_500,
  parameter int BLINK_HALF_PERIOD = 62_500_000,
  parameter int CLIP_HOLD_CYCLES  = 625_000_000
) (
  input  wire            clk,
  input  wire            rst_n,

  // adc stream, always accepted
  input  wire sample_t   adc_data,
  input  wire            adc_valid,
  input  wire            adc_last,
  input  wire sample_t   aux_data,     // third mixer channel

  // host settings and commands
  input  wire mix_ctrl_t mix_ctrl,
  input  wire            clear_peaks,

  // dac stream
  output sample_t        dac_data,
  output logic           dac_valid,
  output logic           dac_last,
  input  wire            dac_ready,

  // status
  output sample_t        peak_max,
  output sample_t        peak_min,
  output logic           led_1,        // clip hold
  output logic           led_2,        // toggles on peak clear
  output logic           led_3,        // blink
  output logic           irq_0,
  output logic           irq_1
);

  mix_frame_t frame;
  logic       frame_valid;
  stereo_t    mix_out;
  logic       mix_valid;
  clip_t      clip;

  // ------------------------------
  // audio path
  // ------------------------------
  adc_ingress adc_ingress_i (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .adc_data    ( adc_data    ),
    .adc_valid   ( adc_valid   ),
    .adc_last    ( adc_last    ),
    .aux_data    ( aux_data    ),
    .clear_peaks ( clear_peaks ),
    .frame       ( frame       ),
    .frame_valid ( frame_valid ),
    .peak_max    ( peak_max    ),
    .peak_min    ( peak_min    ),
    .led_2       ( led_2       )
  );

  channel_mixer channel_mixer_i (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .frame       ( frame       ),
    .frame_valid ( frame_valid ),
    .mix_ctrl    ( mix_ctrl    ),
    .mix_out     ( mix_out     ),
    .mix_valid   ( mix_valid   ),
    .clip        ( clip        )
  );

  dac_egress_fsm dac_egress_fsm_i (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .mix_out   ( mix_out   ),
    .mix_valid ( mix_valid ),
    .dac_ready ( dac_ready ),
    .dac_data  ( dac_data  ),
    .dac_valid ( dac_valid ),
    .dac_last  ( dac_last  )
  );

  clip_monitor #(
    .HOLD_CYCLES ( CLIP_HOLD_CYCLES )
  ) clip_monitor_i (
    .clk   ( clk   ),
    .rst_n ( rst_n ),
    .clip  ( clip  ),
    .led_1 ( led_1 )
  );

  // ------------------------------
  // timers
  // ------------------------------
  event_timer #(
    .PERIOD ( IRQ0_PERIOD )
  ) irq0_timer (
    .clk   ( clk   ),
    .rst_n ( rst_n ),
    .tick  ( irq_0 ),
    .phase (       )
  );

  event_timer #(
    .PERIOD ( IRQ1_PERIOD )
  ) irq1_timer (
    .clk   ( clk   ),
    .rst_n ( rst_n ),
    .tick  ( irq_1 ),
    .phase (       )
  );

  event_timer #(
    .PERIOD ( BLINK_HALF_PERIOD )
  ) blink_timer (
    .clk   ( clk   ),
    .rst_n ( rst_n ),
    .tick  (       ),
    .phase ( led_3 )  // half period per toggle
  );

endmodule

`default_nettype wire

/* verilog/audio_pkg.sv */
/* shared audio definitions: sample and gain widths, Q format,
   frame, stereo, control and clip structs, DAC egress FSM states */

`default_nettype none

package audio_pkg;

  // ------------------------------
  // widths and gain format
  // ------------------------------
  localparam int AUDIO_WIDTH    = 24;
  localparam int GAIN_WIDTH     = 24;
  localparam int Q_BITS         = 11;  // 2048 == unity gain
  localparam int NR_OF_CHANNELS = 3;   // adc left, adc right, aux

  typedef logic signed [AUDIO_WIDTH-1:0] sample_t;
  typedef logic        [GAIN_WIDTH-1:0]  gain_t;    // unsigned Q13.11

  // ------------------------------
  // grouped signals
  // ------------------------------

  // one mixer input frame
  typedef struct packed {
    sample_t [NR_OF_CHANNELS-1:0] ch;  // [0] adc left, [1] adc right, [2] aux
  } mix_frame_t;

  // mixer result, sent left first
  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_t;

  // static host settings, 99 bits
  typedef struct packed {
    gain_t [NR_OF_CHANNELS-1:0] ch_gain;
    logic  [NR_OF_CHANNELS-1:0] pan;       // set = right, clear = left
    gain_t                      out_gain;
  } mix_ctrl_t;

  // saturation flags from the mixer
  typedef struct packed {
    logic [NR_OF_CHANNELS-1:0] ch;   // per channel gain stage
    logic                      out;  // sum or output gain, either side
  } clip_t;

  // ------------------------------
  // dac egress
  // ------------------------------
  typedef enum logic [1:0] {
    WAIT_VALID,
    SEND_LEFT,
    SEND_RIGHT
  } egress_state_t;

endpackage

`default_nettype wire

/* verilog/channel_mixer.sv */
/* three channel mixer: per channel gain, pan to left/right,
   output gain, 24-bit saturation with clip flags, 2-cycle latency */

`timescale 1ns/1ps
`default_nettype none

module channel_mixer import audio_pkg::*; (
  input  wire             clk,
  input  wire             rst_n,
  input  wire mix_frame_t frame,
  input  wire             frame_valid,
  input  wire mix_ctrl_t  mix_ctrl,
  output stereo_t         mix_out,
  output logic            mix_valid,
  output clip_t           clip
);

  localparam int PROD_WIDTH = AUDIO_WIDTH + GAIN_WIDTH + 1;  // signed x zero-extended gain
  localparam int SUM_WIDTH  = AUDIO_WIDTH + $clog2(NR_OF_CHANNELS);
  localparam logic signed [PROD_WIDTH-1:0] SAT_MAX = 2**(AUDIO_WIDTH-1) - 1;
  localparam logic signed [PROD_WIDTH-1:0] SAT_MIN = -(2**(AUDIO_WIDTH-1));

  typedef logic signed [PROD_WIDTH-1:0] wide_t;

  // clamp a wide value into a sample
  function automatic sample_t saturate(input wide_t v, output logic clipped);
    sample_t res;
    clipped = 1'b0;
    res     = sample_t'(v);
    if (v > SAT_MAX) begin
      res     = sample_t'(SAT_MAX);
      clipped = 1'b1;
    end else if (v < SAT_MIN) begin
      res     = sample_t'(SAT_MIN);
      clipped = 1'b1;
    end
    return res;
  endfunction

  // Q13.11 gain, arithmetic shift back, clamp
  function automatic sample_t scale_sat(input sample_t x, input gain_t g,
                                        output logic clipped);
    wide_t prod;
    prod = x * $signed({1'b0, g});
    return saturate(prod >>> Q_BITS, clipped);
  endfunction

  // ------------------------------
  // stage 1: channel gain
  // ------------------------------
  sample_t [NR_OF_CHANNELS-1:0] s1_next;
  sample_t [NR_OF_CHANNELS-1:0] s1_sample;
  logic    [NR_OF_CHANNELS-1:0] s1_clip_next;
  logic    [NR_OF_CHANNELS-1:0] s1_clip;
  logic                         s1_valid;

  always_comb begin
    for (int i = 0; i < NR_OF_CHANNELS; i++) begin
      s1_next[i] = scale_sat(frame.ch[i], mix_ctrl.ch_gain[i], s1_clip_next[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_clip  <= '0;
    end else begin
      s1_valid <= frame_valid;
      s1_clip  <= frame_valid ? s1_clip_next : '0;  // flags only with data
    end
  end

  always_ff @(posedge clk) begin
    if (frame_valid) begin
      s1_sample <= s1_next;
    end
  end

  // ------------------------------
  // stage 2: pan, sum, out gain
  // ------------------------------
  logic signed [SUM_WIDTH-1:0] sum_left;
  logic signed [SUM_WIDTH-1:0] sum_right;
  sample_t                     sat_left;
  sample_t                     sat_right;
  sample_t                     out_left;
  sample_t                     out_right;
  logic                        clip_sum_l;
  logic                        clip_sum_r;
  logic                        clip_gain_l;
  logic                        clip_gain_r;

  always_comb begin
    sum_left  = '0;
    sum_right = '0;
    for (int i = 0; i < NR_OF_CHANNELS; i++) begin
      if (mix_ctrl.pan[i]) begin
        sum_right = sum_right + s1_sample[i];
      end else begin
        sum_left = sum_left + s1_sample[i];
      end
    end
    sat_left  = saturate(wide_t'(sum_left), clip_sum_l);   // sum clamped first
    sat_right = saturate(wide_t'(sum_right), clip_sum_r);
    out_left  = scale_sat(sat_left, mix_ctrl.out_gain, clip_gain_l);
    out_right = scale_sat(sat_right, mix_ctrl.out_gain, clip_gain_r);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mix_valid <= 1'b0;
      clip      <= '0;
    end else begin
      mix_valid <= s1_valid;
      clip.ch   <= s1_clip;  // aligned with mix_valid
      clip.out  <= s1_valid && (clip_sum_l || clip_sum_r || clip_gain_l || clip_gain_r);
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      mix_out.left  <= out_left;
      mix_out.right <= out_right;
    end
  end

endmodule

`default_nettype wire

/* verilog/clip_monitor.sv */
/* clip indicator: any clip lights led_1 for HOLD_CYCLES+1 cycles,
   clips during the hold are ignored */

`timescale 1ns/1ps
`default_nettype none

module clip_monitor import audio_pkg::*; #(
  parameter int HOLD_CYCLES = 625_000_000
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire clip_t clip,
  output logic       led_1
);

  localparam int CNT_WIDTH = (HOLD_CYCLES > 0) ? $clog2(HOLD_CYCLES + 1) : 1;
  localparam logic [CNT_WIDTH-1:0] HOLD_LAST = CNT_WIDTH'(HOLD_CYCLES);

  logic                 hold;
  logic [CNT_WIDTH-1:0] hold_cnt;
  logic                 clip_any;

  assign clip_any = (|clip.ch) || clip.out;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hold     <= 1'b0;
      hold_cnt <= '0;
    end else if (!hold) begin
      if (clip_any) begin
        hold     <= 1'b1;  // lit from the next edge
        hold_cnt <= '0;
      end
    end else if (hold_cnt == HOLD_LAST) begin
      hold <= 1'b0;        // hold over
    end else begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  assign led_1 = hold;

endmodule

`default_nettype wire

/* verilog/dac_egress_fsm.sv */
/* DAC egress FSM: sends each stereo result as a left beat,
   then a right beat with last, under valid/ready */

`timescale 1ns/1ps
`default_nettype none

module dac_egress_fsm import audio_pkg::*; (
  input  wire          clk,
  input  wire          rst_n,
  input  wire stereo_t mix_out,
  input  wire          mix_valid,
  input  wire          dac_ready,
  output sample_t      dac_data,
  output logic         dac_valid,
  output logic         dac_last
);

  egress_state_t state;
  sample_t       right_q;  // right sample waits here during the left beat
  logic          load;
  logic          left_done;
  logic          right_done;

  // mix_valid outside WAIT_VALID is dropped
  assign load       = (state == WAIT_VALID) && mix_valid;
  assign left_done  = (state == SEND_LEFT) && dac_ready;
  assign right_done = (state == SEND_RIGHT) && dac_ready;

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= WAIT_VALID;
      dac_valid <= 1'b0;
      dac_last  <= 1'b0;
    end else begin
      case (state)
        WAIT_VALID: begin
          if (load) begin
            state     <= SEND_LEFT;
            dac_valid <= 1'b1;
            dac_last  <= 1'b0;
          end
        end
        SEND_LEFT: begin
          if (left_done) begin
            state    <= SEND_RIGHT;
            dac_last <= 1'b1;  // right beat closes the pair
          end
        end
        SEND_RIGHT: begin
          if (right_done) begin
            state     <= WAIT_VALID;
            dac_valid <= 1'b0;
            dac_last  <= 1'b0;
          end
        end
        default: state <= WAIT_VALID;
      endcase
    end
  end

  // ------------------------------
  // data path, held unless a beat moves
  // ------------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      dac_data <= mix_out.left;
      right_q  <= mix_out.right;
    end else if (left_done) begin
      dac_data <= right_q;
    end
  end

endmodule

`default_nettype wire

/* verilog/event_timer.sv */
/* free-running period timer with a one-cycle tick and a phase
   that toggles on every tick */

`timescale 1ns/1ps
`default_nettype none

module event_timer #(
  parameter int PERIOD = 12_500
) (
  input  wire  clk,
  input  wire  rst_n,
  output logic tick,
  output logic phase
);

  localparam int CNT_WIDTH = (PERIOD > 1) ? $clog2(PERIOD) : 1;
  localparam logic [CNT_WIDTH-1:0] LAST = CNT_WIDTH'(PERIOD - 1);

  logic [CNT_WIDTH-1:0] cnt;
  logic                 wrap;

  assign wrap = (cnt == LAST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      tick  <= 1'b0;
      phase <= 1'b0;
    end else begin
      tick <= wrap;  // first tick PERIOD cycles after reset
      if (wrap) begin
        cnt   <= '0;
        phase <= ~phase;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire
